/* project.f */
+incdir+include
design/softex_ctrl_pkg.sv
design/softex_cmd_regs.sv
design/softex_slot_ctrl.sv
design/softex_ctrl_fsm.sv
design/softex_ctrl_top.sv
bench/softex_ctrl_tb.sv

/* Bender.yml */
package:
  name: softex_ctrl

export_include_dirs:
  - include

sources:
  - design/softex_ctrl_pkg.sv
  - design/softex_cmd_regs.sv
  - design/softex_slot_ctrl.sv
  - design/softex_ctrl_fsm.sv
  - design/softex_ctrl_top.sv
  - target: test
    files:
      - bench/softex_ctrl_tb.sv

/* bench/softex_ctrl_vectors.txt */
# name len cmd slot_valid max den rcp, then expected: beats req_op upd_op upd_den upd_valid
# All numbers hex. Ops: 0 ALLOC, 1 LOAD, 2 UPDATE, 3 FREE
full_exact     00000100 00000000 1 1a2b 00012000 0000d800 00000010 0 0 00000000 0
full_partial   00000105 00000000 0 0c3d 00034000 00004c00 00000011 0 0 00000000 0
acc_alloc      00000040 00030011 1 2f00 00045000 00003900 00000004 0 2 00045000 1
acc_load_wait  0000003f 00030001 0 2f10 00056000 00002e00 00000004 1 2 00056000 1
acc_last       00000080 00030005 1 3001 00067000 00002600 00000008 1 2 00002600 1
div_last_wait  00000081 00030006 0 3002 00078000 00002200 00000009 1 3 00002200 1
div_mid        00000200 00070002 1 3003 00089000 00001e00 00000020 1 0 00000000 0
acc_last_alloc 00000030 00090015 0 3004 0009a000 00001b00 00000003 0 2 00001b00 1
noop_cache     00000010 00000028 1 0000 00000000 00000000 00000001 0 0 00000000 0
full_cache     00000001 00000008 1 1111 000ab000 00001800 00000001 0 0 00000000 0

/* bench/softex_ctrl_tb.sv */
// Softmax controller testbench
// Replays operations from the vector file against models of the streamers,
// the datapath and the slot store, and checks strobes, slot traffic and lengths

`timescale 1ns/1ps
`default_nettype none

`include "softex_settings.svh"

module softex_ctrl_tb;

    localparam int PERIOD  = 40;
    localparam int MAX_VEC = 16;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          reg_we_i;
    softex_ctrl_pkg::reg_idx_t     reg_idx_i;
    softex_ctrl_pkg::word_t        reg_wdata_i;
    logic                          in_stream_done_i;
    logic                          out_stream_done_i;
    softex_ctrl_pkg::dp_flags_t    dp_flags_i;
    logic                          slot_valid_i;
    softex_ctrl_pkg::stream_ctrl_t in_stream_o;
    softex_ctrl_pkg::stream_ctrl_t out_stream_o;
    softex_ctrl_pkg::dp_ctrl_t     dp_ctrl_o;
    softex_ctrl_pkg::slot_req_t    slot_req_o;
    softex_ctrl_pkg::slot_upd_t    slot_upd_o;
    softex_ctrl_pkg::addr_t        cache_base_o;
    logic                          busy_o;
    logic                          done_o;

    // One entry per vector line
    string                  vec_name  [MAX_VEC];
    softex_ctrl_pkg::word_t vec_len   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_cmd   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_sv    [MAX_VEC];
    softex_ctrl_pkg::word_t vec_max   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_den   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_rcp   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_beats [MAX_VEC];
    softex_ctrl_pkg::word_t vec_req   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_upd   [MAX_VEC];
    softex_ctrl_pkg::word_t vec_uden  [MAX_VEC];
    softex_ctrl_pkg::word_t vec_uval  [MAX_VEC];
    int                     num_vec    = 0;
    logic                   vec_loaded = 1'b0;

    softex_ctrl_pkg::cmd_t    cur_cmd = '0;
    softex_ctrl_pkg::slot_op_e upd_op;
    softex_ctrl_pkg::den_t    upd_den;
    softex_ctrl_pkg::slot_idx_t upd_addr;
    softex_ctrl_pkg::max_t      upd_max;
    int   n_in_start  = 0;
    int   n_out_start = 0;
    int   n_done      = 0;
    int   n_load_max  = 0;
    int   n_load_den  = 0;
    int   n_load_rcp  = 0;
    int   n_upd       = 0;
    int   in_cnt      = 0;
    int   out_cnt     = 0;
    int   acc_cnt     = 0;
    int   inv_cnt     = 0;
    logic in_seen     = 1'b0;
    logic out_seen    = 1'b0;
    logic acc_seen    = 1'b0;
    logic acc_armed   = 1'b0;
    logic model_idle  = 1'b1;

    softex_ctrl_top u_dut (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .reg_we_i          (reg_we_i),
        .reg_idx_i         (reg_idx_i),
        .reg_wdata_i       (reg_wdata_i),
        .in_stream_done_i  (in_stream_done_i),
        .out_stream_done_i (out_stream_done_i),
        .dp_flags_i        (dp_flags_i),
        .slot_valid_i      (slot_valid_i),
        .in_stream_o       (in_stream_o),
        .out_stream_o      (out_stream_o),
        .dp_ctrl_o         (dp_ctrl_o),
        .slot_req_o        (slot_req_o),
        .slot_upd_o        (slot_upd_o),
        .cache_base_o      (cache_base_o),
        .busy_o            (busy_o),
        .done_o            (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic fail_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] %0s: expected %0h, actual %0h", what, exp, act);
        stop_run();
    endtask

    task automatic check_len(input string what, input softex_ctrl_pkg::len_t exp,
                             input softex_ctrl_pkg::len_t act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_op(input string what, input softex_ctrl_pkg::slot_op_e exp,
                            input softex_ctrl_pkg::slot_op_e act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_den(input string what, input softex_ctrl_pkg::den_t exp,
                             input softex_ctrl_pkg::den_t act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_addr(input string what, input softex_ctrl_pkg::addr_t exp,
                              input softex_ctrl_pkg::addr_t act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_slot(input string what, input softex_ctrl_pkg::slot_idx_t exp,
                              input softex_ctrl_pkg::slot_idx_t act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_max(input string what, input softex_ctrl_pkg::max_t exp,
                             input softex_ctrl_pkg::max_t act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) fail_value(what, exp, act);
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) fail_value(what, exp, act);
    endtask

    task automatic write_reg(input int idx, input softex_ctrl_pkg::word_t data);
        @(negedge clk_i);
        reg_we_i    = 1'b1;
        reg_idx_i   = softex_ctrl_pkg::reg_idx_t'(idx);
        reg_wdata_i = data;
    endtask

    function automatic int draw_delay();
        return int'($urandom % 8) + 1;
    endfunction

    // Event counts and start flags, taken before the edge updates the DUT
    always @(posedge clk_i) begin
        if (rst_ni) begin
            n_in_start  = n_in_start + int'(in_stream_o.start);
            n_out_start = n_out_start + int'(out_stream_o.start);
            n_done      = n_done + int'(done_o);
            n_load_max  = n_load_max + int'(dp_ctrl_o.load_max);
            n_load_den  = n_load_den + int'(dp_ctrl_o.load_denominator);
            n_load_rcp  = n_load_rcp + int'(dp_ctrl_o.load_reciprocal);
            if (slot_upd_o.valid) begin
                n_upd    = n_upd + 1;
                upd_op   = slot_upd_o.op;
                upd_den  = slot_upd_o.denominator;
                upd_addr = slot_upd_o.addr;
                upd_max  = slot_upd_o.maximum;
            end
            in_seen    = in_stream_o.start;
            out_seen   = out_stream_o.start;
            acc_seen   = dp_ctrl_o.acc_finished;
            model_idle = (in_cnt == 0) && (out_cnt == 0) && (acc_cnt == 0) && (inv_cnt == 0);
        end
    end

    // Streamer and datapath model
    initial begin : respond
        logic inv_idle;
        void'($urandom(32'h94d2));
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                inv_idle            = (inv_cnt == 0);
                in_stream_done_i    = 1'b0;
                out_stream_done_i   = 1'b0;
                dp_flags_i.acc_done = 1'b0;
                dp_flags_i.inv_done = 1'b0;
                if (in_cnt > 0) begin
                    in_cnt           = in_cnt - 1;
                    in_stream_done_i = (in_cnt == 0);
                end
                if (out_cnt > 0 && inv_idle) begin  // Output beats wait for the reciprocal
                    out_cnt           = out_cnt - 1;
                    out_stream_done_i = (out_cnt == 0);
                end
                if (inv_cnt > 0) begin
                    inv_cnt             = inv_cnt - 1;
                    dp_flags_i.inv_done = (inv_cnt == 0);
                end
                if (acc_cnt > 0) begin
                    acc_cnt             = acc_cnt - 1;
                    dp_flags_i.acc_done = (acc_cnt == 0);
                    if (acc_cnt == 0 && (!cur_cmd.acc_only || cur_cmd.last)) begin
                        inv_cnt = draw_delay();
                    end
                end
                if (in_seen) in_cnt = draw_delay();
                if (out_seen) out_cnt = draw_delay();
                if (acc_seen && !acc_armed) begin
                    acc_cnt   = draw_delay();
                    acc_armed = 1'b1;
                end
                if (!acc_seen) acc_armed = 1'b0;
                dp_flags_i.datapath_busy = (in_cnt > 0);
            end
        end
    end

    initial begin
        wait (vec_loaded);
        #(num_vec * 200 * PERIOD);
        $display("Watchdog expired before all vector lines completed");
        stop_run();
    end

    initial begin
        int                     fd;
        int                     exp_in;
        int                     exp_out;
        logic                   partial;
        logic                   exp_load;
        string                  line;
        string                  tag;
        softex_ctrl_pkg::addr_t cache_addr;
        rst_ni       = 1'b0;
        reg_we_i     = 1'b0;
        reg_idx_i    = '0;
        reg_wdata_i  = '0;
        in_stream_done_i  = 1'b0;
        out_stream_done_i = 1'b0;
        dp_flags_i   = '0;
        slot_valid_i = 1'b0;
        fd = $fopen("bench/softex_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            stop_run();
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", vec_name[num_vec],
                            vec_len[num_vec], vec_cmd[num_vec], vec_sv[num_vec],
                            vec_max[num_vec], vec_den[num_vec], vec_rcp[num_vec],
                            vec_beats[num_vec], vec_req[num_vec], vec_upd[num_vec],
                            vec_uden[num_vec], vec_uval[num_vec]) == 12) begin
                    num_vec = num_vec + 1;
                end
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("The vector file holds no usable lines");
            stop_run();
        end
        vec_loaded = 1'b1;

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_flag("reset busy_o", 1'b0, busy_o);
        check_flag("reset done_o", 1'b0, done_o);
        check_flag("reset in start", 1'b0, in_stream_o.start);

        for (int i = 0; i < num_vec; i++) begin
            tag        = vec_name[i];
            // Slot index in the top half, flags in the low six bits
            cur_cmd    = softex_ctrl_pkg::cmd_t'({vec_cmd[i][31:16], vec_cmd[i][5:0]});
            partial    = cur_cmd.acc_only | cur_cmd.div_only;
            cache_addr = 32'h3000_0000 + (i << 6);
            dp_flags_i.max         = vec_max[i][15:0];
            dp_flags_i.denominator = vec_den[i];
            dp_flags_i.reciprocal  = vec_rcp[i];
            write_reg(`SOFTEX_REG_IN_ADDR, 32'h1000_0000 + (i << 8));
            write_reg(`SOFTEX_REG_OUT_ADDR, 32'h2000_0000 + (i << 8));
            write_reg(`SOFTEX_REG_TOT_LEN, vec_len[i]);
            write_reg(`SOFTEX_REG_CACHE_ADDR, cache_addr);
            n_in_start  = 0;
            n_out_start = 0;
            n_done      = 0;
            n_load_max  = 0;
            n_load_den  = 0;
            n_load_rcp  = 0;
            n_upd       = 0;
            slot_valid_i = vec_sv[i][0];
            write_reg(`SOFTEX_REG_COMMANDS, vec_cmd[i]);
            #1;
            // The slot store sees the request while the command is being written
            check_flag({tag, " req valid"}, partial, slot_req_o.valid);
            if (partial) begin
                check_op({tag, " req op"}, softex_ctrl_pkg::slot_op_e'(vec_req[i][1:0]),
                         slot_req_o.op);
                check_slot({tag, " req addr"}, cur_cmd.slot_idx, slot_req_o.addr);
            end
            @(negedge clk_i);
            reg_we_i = 1'b0;
            if (partial && !vec_sv[i][0]) begin
                repeat (4) @(negedge clk_i);
                check_count({tag, " start before slot valid"}, 0, n_in_start);
                check_flag({tag, " busy waiting for slot"}, 1'b1, busy_o);
                slot_valid_i = 1'b1;
            end
            while (n_done == 0) @(negedge clk_i);
            while (!model_idle) @(negedge clk_i);
            @(negedge clk_i);

            exp_in   = cur_cmd.no_op ? 0 : (partial ? 1 : 2);
            exp_out  = (cur_cmd.no_op || cur_cmd.acc_only) ? 0 : 1;
            exp_load = partial && !cur_cmd.acquire_slot && !cur_cmd.no_op;
            check_count({tag, " done pulses"}, 1, n_done);
            check_count({tag, " in starts"}, exp_in, n_in_start);
            check_count({tag, " out starts"}, exp_out, n_out_start);
            check_count({tag, " load max"}, int'(exp_load), n_load_max);
            check_count({tag, " load den"}, int'(exp_load && !cur_cmd.div_only), n_load_den);
            check_count({tag, " load rcp"}, int'(exp_load && cur_cmd.div_only), n_load_rcp);
            check_count({tag, " updates"}, int'(vec_uval[i]), n_upd);
            if (vec_uval[i][0]) begin
                check_op({tag, " upd op"}, softex_ctrl_pkg::slot_op_e'(vec_upd[i][1:0]), upd_op);
                check_den({tag, " upd den"}, vec_uden[i], upd_den);
                check_slot({tag, " upd addr"}, cur_cmd.slot_idx, upd_addr);
                check_max({tag, " upd max"}, vec_max[i][15:0], upd_max);
            end
            check_len({tag, " in tot_len"}, vec_beats[i], in_stream_o.tot_len);
            check_len({tag, " out tot_len"}, vec_beats[i], out_stream_o.tot_len);
            check_addr({tag, " in base"}, 32'h1000_0000 + (i << 8), in_stream_o.base);
            check_addr({tag, " out base"}, 32'h2000_0000 + (i << 8), out_stream_o.base);
            check_flag({tag, " busy after done"}, 1'b0, busy_o);
            if (cur_cmd.set_cache_addr) begin
                check_addr({tag, " cache base"}, cache_addr, cache_base_o);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* design/softex_ctrl_top.sv */
// Softmax accelerator controller top level
// Joins the register file, the sequencer and the state-slot logic

`timescale 1ns/1ps
`default_nettype none

module softex_ctrl_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          reg_we_i,
    input  softex_ctrl_pkg::reg_idx_t     reg_idx_i,
    input  softex_ctrl_pkg::word_t        reg_wdata_i,
    input  logic                          in_stream_done_i,
    input  logic                          out_stream_done_i,
    input  softex_ctrl_pkg::dp_flags_t    dp_flags_i,
    input  logic                          slot_valid_i,
    output softex_ctrl_pkg::stream_ctrl_t in_stream_o,
    output softex_ctrl_pkg::stream_ctrl_t out_stream_o,
    output softex_ctrl_pkg::dp_ctrl_t     dp_ctrl_o,
    output softex_ctrl_pkg::slot_req_t    slot_req_o,
    output softex_ctrl_pkg::slot_upd_t    slot_upd_o,
    output softex_ctrl_pkg::addr_t        cache_base_o,
    output logic                          busy_o,
    output logic                          done_o
);

    softex_ctrl_pkg::cmd_t  cmd;
    softex_ctrl_pkg::addr_t in_addr;
    softex_ctrl_pkg::addr_t out_addr;
    softex_ctrl_pkg::len_t  tot_len;
    logic                   trigger;
    logic                   cache_load;
    logic                   in_start;
    logic                   out_start;
    logic                   upd_en;

    softex_cmd_regs u_cmd_regs (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .reg_we_i     (reg_we_i),
        .reg_idx_i    (reg_idx_i),
        .reg_wdata_i  (reg_wdata_i),
        .cache_load_i (cache_load),
        .cmd_o        (cmd),
        .in_addr_o    (in_addr),
        .out_addr_o   (out_addr),
        .cache_base_o (cache_base_o),
        .tot_len_o    (tot_len),
        .trigger_o    (trigger)
    );

    softex_slot_ctrl u_slot_ctrl (
        .reg_we_i    (reg_we_i),
        .reg_idx_i   (reg_idx_i),
        .reg_wdata_i (reg_wdata_i),
        .cmd_i       (cmd),
        .upd_en_i    (upd_en),
        .dp_flags_i  (dp_flags_i),
        .slot_req_o  (slot_req_o),
        .slot_upd_o  (slot_upd_o)
    );

    softex_ctrl_fsm u_ctrl_fsm (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .trigger_i         (trigger),
        .cmd_i             (cmd),
        .in_stream_done_i  (in_stream_done_i),
        .out_stream_done_i (out_stream_done_i),
        .dp_flags_i        (dp_flags_i),
        .slot_valid_i      (slot_valid_i),
        .in_start_o        (in_start),
        .out_start_o       (out_start),
        .dp_ctrl_o         (dp_ctrl_o),
        .cache_load_o      (cache_load),
        .upd_en_o          (upd_en),
        .busy_o            (busy_o),
        .done_o            (done_o)
    );

    // Both streams move the same number of beats
    assign in_stream_o  = '{start: in_start, base: in_addr, tot_len: tot_len};
    assign out_stream_o = '{start: out_start, base: out_addr, tot_len: tot_len};

endmodule

`default_nettype wire

/* design/softex_ctrl_fsm.sv */
// Softmax operation sequencer
// Steps through accumulation, inversion and division, starts the streams
// and drives the datapath control and slot load strobes

`timescale 1ns/1ps
`default_nettype none

module softex_ctrl_fsm (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       trigger_i,
    input  softex_ctrl_pkg::cmd_t      cmd_i,
    input  logic                       in_stream_done_i,
    input  logic                       out_stream_done_i,
    input  softex_ctrl_pkg::dp_flags_t dp_flags_i,
    input  logic                       slot_valid_i,
    output logic                       in_start_o,
    output logic                       out_start_o,
    output softex_ctrl_pkg::dp_ctrl_t  dp_ctrl_o,
    output logic                       cache_load_o,
    output logic                       upd_en_o,
    output logic                       busy_o,
    output logic                       done_o
);

    softex_ctrl_pkg::ctrl_state_e state_q;
    softex_ctrl_pkg::ctrl_state_e state_d;
    logic                         partial;
    logic                         launch;

    assign partial = cmd_i.acc_only | cmd_i.div_only;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= softex_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d            = state_q;
        launch             = 1'b0;
        in_start_o         = 1'b0;
        out_start_o        = 1'b0;
        dp_ctrl_o          = '0;
        dp_ctrl_o.acc_only = cmd_i.acc_only & ~cmd_i.last;
        cache_load_o       = 1'b0;
        upd_en_o           = 1'b0;
        busy_o             = 1'b1;
        done_o             = 1'b0;

        unique case (state_q)
            softex_ctrl_pkg::IDLE: begin
                busy_o = 1'b0;
                if (trigger_i) begin
                    cache_load_o = cmd_i.set_cache_addr;
                    if (cmd_i.no_op) begin
                        done_o = 1'b1;
                    end else if (partial && !slot_valid_i) begin
                        state_d = softex_ctrl_pkg::WAIT_SLOT_VALID;
                    end else begin
                        launch = 1'b1;
                    end
                end
            end

            softex_ctrl_pkg::WAIT_SLOT_VALID: begin
                launch = slot_valid_i;
            end

            softex_ctrl_pkg::ACCUMULATION: begin
                if (in_stream_done_i) begin
                    state_d = softex_ctrl_pkg::WAIT_DATAPATH_EMPTY;
                end
            end

            softex_ctrl_pkg::WAIT_DATAPATH_EMPTY: begin
                if (!dp_flags_i.datapath_busy) begin
                    state_d                = softex_ctrl_pkg::WAIT_ACCUMULATION;
                    dp_ctrl_o.acc_finished = 1'b1;
                end
            end

            softex_ctrl_pkg::WAIT_ACCUMULATION: begin
                dp_ctrl_o.acc_finished = 1'b1;
                dp_ctrl_o.disable_max  = 1'b1;
                if (dp_flags_i.acc_done) begin
                    if (cmd_i.acc_only && !cmd_i.last) begin
                        state_d = softex_ctrl_pkg::FINISHED;
                    end else begin
                        state_d = softex_ctrl_pkg::WAIT_INVERSION;
                        // A full softmax re-reads the input while the sum inverts
                        if (!cmd_i.acc_only) begin
                            dp_ctrl_o.acc_finished = 1'b0;
                            in_start_o             = 1'b1;
                            out_start_o            = 1'b1;
                        end
                    end
                end
            end

            softex_ctrl_pkg::WAIT_INVERSION: begin
                dp_ctrl_o.dividing    = 1'b1;
                dp_ctrl_o.disable_max = 1'b1;
                if (dp_flags_i.inv_done) begin
                    state_d = cmd_i.acc_only ? softex_ctrl_pkg::FINISHED
                                             : softex_ctrl_pkg::DIVIDING;
                end
            end

            softex_ctrl_pkg::DIVIDING: begin
                dp_ctrl_o.dividing    = 1'b1;
                dp_ctrl_o.disable_max = 1'b1;
                if (out_stream_done_i) begin
                    state_d = softex_ctrl_pkg::FINISHED;
                end
            end

            softex_ctrl_pkg::FINISHED: begin
                busy_o               = 1'b0;
                done_o               = 1'b1;
                dp_ctrl_o.clear_regs = 1'b1;
                upd_en_o             = cmd_i.acc_only | (cmd_i.div_only & cmd_i.last);
                state_d              = softex_ctrl_pkg::IDLE;
            end

            default: begin
                state_d = softex_ctrl_pkg::IDLE;
            end
        endcase

        // Common start from IDLE or once the slot arrives
        if (launch) begin
            in_start_o  = 1'b1;
            out_start_o = cmd_i.div_only;
            state_d     = cmd_i.div_only ? softex_ctrl_pkg::DIVIDING
                                         : softex_ctrl_pkg::ACCUMULATION;
            if (partial && !cmd_i.acquire_slot) begin
                dp_ctrl_o.load_max         = 1'b1;  // Resume from the stored slot
                dp_ctrl_o.load_denominator = ~cmd_i.div_only;
                dp_ctrl_o.load_reciprocal  = cmd_i.div_only;
            end
        end
    end

    // Done is never followed by a busy cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |-> !busy_o ##1 !busy_o);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        upd_en_o |-> (state_q == softex_ctrl_pkg::FINISHED)
                     ##1 (state_q == softex_ctrl_pkg::IDLE));

endmodule

`default_nettype wire

/* design/softex_slot_ctrl.sv */
// Softmax state-slot operations
// Requests a slot straight from the command write and builds the
// writeback of the running maximum and denominator on finish

`timescale 1ns/1ps
`default_nettype none

`include "softex_settings.svh"

module softex_slot_ctrl (
    input  logic                       reg_we_i,
    input  softex_ctrl_pkg::reg_idx_t  reg_idx_i,
    input  softex_ctrl_pkg::word_t     reg_wdata_i,
    input  softex_ctrl_pkg::cmd_t      cmd_i,
    input  logic                       upd_en_i,
    input  softex_ctrl_pkg::dp_flags_t dp_flags_i,
    output softex_ctrl_pkg::slot_req_t slot_req_o,
    output softex_ctrl_pkg::slot_upd_t slot_upd_o
);

    logic cmd_we;
    logic partial;

    // Decoded from the raw write so the store can fetch while the command latches
    assign cmd_we  = reg_we_i && (reg_idx_i == softex_ctrl_pkg::reg_idx_t'(`SOFTEX_REG_COMMANDS));
    assign partial = reg_wdata_i[`SOFTEX_CMD_ACC_ONLY] | reg_wdata_i[`SOFTEX_CMD_DIV_ONLY];

    assign slot_req_o.valid = cmd_we && partial;
    assign slot_req_o.op    = reg_wdata_i[`SOFTEX_CMD_ACQUIRE_SLOT] ? softex_ctrl_pkg::ALLOC
                                                                    : softex_ctrl_pkg::LOAD;
    assign slot_req_o.addr  = reg_wdata_i[31 -: `SOFTEX_SLOT_WIDTH];

    assign slot_upd_o.valid   = upd_en_i;
    assign slot_upd_o.op      = (cmd_i.last && cmd_i.div_only) ? softex_ctrl_pkg::FREE
                                                               : softex_ctrl_pkg::UPDATE;
    assign slot_upd_o.addr    = cmd_i.slot_idx;
    assign slot_upd_o.maximum = dp_flags_i.max;

    // Only an intermediate accumulation stores the raw sum
    assign slot_upd_o.denominator = (cmd_i.acc_only && !cmd_i.last) ? dp_flags_i.denominator
                                                                    : dp_flags_i.reciprocal;

endmodule

`default_nettype wire

/* design/softex_cmd_regs.sv */
// Softmax controller register file
// Holds the addresses, length and command word, decodes the command,
// pulses a trigger after each command write and keeps the slot cache base

`timescale 1ns/1ps
`default_nettype none

`include "softex_settings.svh"

module softex_cmd_regs (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      reg_we_i,
    input  softex_ctrl_pkg::reg_idx_t reg_idx_i,
    input  softex_ctrl_pkg::word_t    reg_wdata_i,
    input  logic                      cache_load_i,
    output softex_ctrl_pkg::cmd_t     cmd_o,
    output softex_ctrl_pkg::addr_t    in_addr_o,
    output softex_ctrl_pkg::addr_t    out_addr_o,
    output softex_ctrl_pkg::addr_t    cache_base_o,
    output softex_ctrl_pkg::len_t     tot_len_o,
    output logic                      trigger_o
);

    localparam int unsigned NUM_REGS   = `SOFTEX_REG_COMMANDS + 1;
    localparam int unsigned WORD_BYTES = `SOFTEX_DATA_WIDTH / 8;
    localparam int unsigned OFS_WIDTH  = $clog2(WORD_BYTES);

    softex_ctrl_pkg::word_t regs_q [NUM_REGS];
    softex_ctrl_pkg::word_t cmd_word;
    softex_ctrl_pkg::word_t tot_bytes;
    softex_ctrl_pkg::addr_t cache_base_q;
    logic                   cmd_we;
    logic                   trigger_q;
    logic                   lftovr_inc;

    assign cmd_we = reg_we_i && (reg_idx_i == softex_ctrl_pkg::reg_idx_t'(`SOFTEX_REG_COMMANDS));

    // Indices past COMMANDS address nothing
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '{default: '0};
        end else if (reg_we_i && (int'(reg_idx_i) < NUM_REGS)) begin
            regs_q[reg_idx_i] <= reg_wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trigger_q    <= 1'b0;
            cache_base_q <= '0;
        end else begin
            trigger_q <= cmd_we;  // Command is latched in the same edge
            if (cache_load_i) begin
                cache_base_q <= regs_q[`SOFTEX_REG_CACHE_ADDR];
            end
        end
    end

    assign cmd_word = regs_q[`SOFTEX_REG_COMMANDS];

    assign cmd_o.acc_only       = cmd_word[`SOFTEX_CMD_ACC_ONLY];
    assign cmd_o.div_only       = cmd_word[`SOFTEX_CMD_DIV_ONLY];
    assign cmd_o.last           = cmd_word[`SOFTEX_CMD_LAST];
    assign cmd_o.set_cache_addr = cmd_word[`SOFTEX_CMD_SET_CACHE_ADDR];
    assign cmd_o.acquire_slot   = cmd_word[`SOFTEX_CMD_ACQUIRE_SLOT];
    assign cmd_o.no_op          = cmd_word[`SOFTEX_CMD_NO_OP];
    assign cmd_o.slot_idx       = cmd_word[31 -: `SOFTEX_SLOT_WIDTH];

    // A partial last word still costs a full beat
    assign tot_bytes  = regs_q[`SOFTEX_REG_TOT_LEN];
    assign lftovr_inc = tot_bytes[OFS_WIDTH-1:0] != '0;
    assign tot_len_o  = softex_ctrl_pkg::len_t'(tot_bytes >> OFS_WIDTH)
                      + softex_ctrl_pkg::len_t'(lftovr_inc);

    assign in_addr_o    = regs_q[`SOFTEX_REG_IN_ADDR];
    assign out_addr_o   = regs_q[`SOFTEX_REG_OUT_ADDR];
    assign cache_base_o = cache_base_q;
    assign trigger_o    = trigger_q;

    // Back-to-back triggers need back-to-back command writes
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (trigger_o && $past(trigger_o)) |-> $past(cmd_we));

endmodule

`default_nettype wire

/* design/softex_ctrl_pkg.sv */
// Softmax controller types
// Vector types, state and slot enums, and the structs that cross module ports

`default_nettype none

`include "softex_settings.svh"

package softex_ctrl_pkg;

    typedef logic [`SOFTEX_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`SOFTEX_REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [31:0]                      word_t;
    typedef logic [`SOFTEX_LEN_WIDTH-1:0]     len_t;
    typedef logic [`SOFTEX_SLOT_WIDTH-1:0]    slot_idx_t;
    typedef logic [`SOFTEX_MAX_WIDTH-1:0]     max_t;
    typedef logic [`SOFTEX_DEN_WIDTH-1:0]     den_t;

    typedef struct packed {
        slot_idx_t slot_idx;
        logic      no_op;
        logic      acquire_slot;
        logic      set_cache_addr;
        logic      last;
        logic      div_only;
        logic      acc_only;
    } cmd_t;

    typedef struct packed {
        logic  start;
        addr_t base;
        len_t  tot_len;  // In stream beats
    } stream_ctrl_t;

    typedef struct packed {
        logic acc_finished;
        logic acc_only;
        logic dividing;
        logic disable_max;
        logic clear_regs;
        logic load_max;
        logic load_denominator;
        logic load_reciprocal;
    } dp_ctrl_t;

    typedef struct packed {
        logic datapath_busy;
        logic acc_done;
        logic inv_done;
        max_t max;
        den_t denominator;
        den_t reciprocal;
    } dp_flags_t;

    typedef enum logic [1:0] {
        ALLOC,
        LOAD,
        UPDATE,
        FREE
    } slot_op_e;

    typedef struct packed {
        logic      valid;
        slot_op_e  op;
        slot_idx_t addr;
    } slot_req_t;

    typedef struct packed {
        logic      valid;
        slot_op_e  op;
        slot_idx_t addr;
        max_t      maximum;
        den_t      denominator;
    } slot_upd_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_SLOT_VALID,
        ACCUMULATION,
        WAIT_DATAPATH_EMPTY,
        WAIT_ACCUMULATION,
        WAIT_INVERSION,
        DIVIDING,
        FINISHED
    } ctrl_state_e;

endpackage

`default_nettype wire

/* include/softex_settings.svh */
// Softmax accelerator controller settings
// Widths, register indices and command word bit positions

`ifndef SOFTEX_SETTINGS_SVH
`define SOFTEX_SETTINGS_SVH

`define SOFTEX_DATA_WIDTH    128
`define SOFTEX_ADDR_WIDTH    32
`define SOFTEX_REG_IDX_WIDTH 3
`define SOFTEX_SLOT_WIDTH    16
`define SOFTEX_MAX_WIDTH     16
`define SOFTEX_DEN_WIDTH     32
`define SOFTEX_LEN_WIDTH     32

`define SOFTEX_REG_IN_ADDR    0
`define SOFTEX_REG_OUT_ADDR   1
`define SOFTEX_REG_TOT_LEN    2
`define SOFTEX_REG_CACHE_ADDR 3
`define SOFTEX_REG_COMMANDS   4  // Writing this register starts an operation

// Slot index sits in the top 16 bits of the command word
`define SOFTEX_CMD_ACC_ONLY       0
`define SOFTEX_CMD_DIV_ONLY       1
`define SOFTEX_CMD_LAST           2
`define SOFTEX_CMD_SET_CACHE_ADDR 3
`define SOFTEX_CMD_ACQUIRE_SLOT   4
`define SOFTEX_CMD_NO_OP          5

`endif
